// File: flist.f
+incdir+include
hdl/wb_pkg.sv
hdl/retire_queue.sv
hdl/writeback_stage.sv
hdl/reg_file.sv
hdl/wb_top.sv
test/tb_wb_top.sv

// File: hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_defs.svh"

module reg_file (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wb_pkg::rf_write_s   wr_i,
    input  wire logic [4:0]     rd_addr_i,
    output logic [31:0]         rd_data_o
);

    localparam int NUM_REGS = `WB_NUM_REGS;

    logic [31:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.en && (wr_i.addr != 5'd0)) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    // x0 reads zero, no bypass of a same-edge write
    assign rd_data_o = (rd_addr_i == 5'd0) ? 32'd0 : regs[rd_addr_i];

    a_wr_addr_known: assert property (
        @(posedge clk) disable iff (reset_i)
        wr_i.en |-> !$isunknown(wr_i.addr)
    ) else $error("reg_file: write enabled with unknown address");

endmodule

`default_nettype wire

// File: hdl/retire_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_defs.svh"

module retire_queue (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               pkt_valid_i,
    input  wb_pkg::retire_pkt_s     pkt_i,
    output logic                    head_valid_o,
    output wb_pkg::retire_pkt_s     head_pkt_o,
    output logic                    credit_o
);

    import wb_pkg::*;

    localparam int DEPTH = `WB_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    retire_pkt_s mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // no stall downstream, so the head leaves every cycle it is there
    assign push = pkt_valid_i;
    assign pop  = (count != '0);

    assign head_valid_o = pop;
    assign head_pkt_o   = mem[rd_ptr];

    // payload storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= pkt_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
            // one credit back per freed entry
            credit_o <= pop;
        end
    end

    // upstream must respect its credits
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (reset_i)
        pkt_valid_i |-> (count != CNT_W'(DEPTH))
    ) else $error("retire_queue: packet sent while queue full");

    a_count_in_range: assert property (
        @(posedge clk) disable iff (reset_i)
        count <= CNT_W'(DEPTH)
    ) else $error("retire_queue: occupancy above depth");

endmodule

`default_nettype wire

// File: hdl/wb_pkg.sv
`default_nettype none

package wb_pkg;

    // write-back source select, unknown codes fall back to the alu
    typedef enum logic [3:0] {
        WB_ALU   = 4'd0,
        WB_MEMB  = 4'd1,
        WB_MEMBU = 4'd2,
        WB_MEMH  = 4'd3,
        WB_MEMHU = 4'd4,
        WB_MEMW  = 4'd5,
        WB_PC    = 4'd6,
        WB_CSR   = 4'd7
    } wb_sel_e;

    // csr commands, only the trap group redirects at retire
    typedef enum logic [2:0] {
        CSR_NONE  = 3'd0,
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5,
        CSR_SRET  = 3'd6
    } csr_cmd_e;

    // raw load word, seen whole or split into bytes and halfwords
    typedef union packed {
        logic [31:0]      word;
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } load_word_u;

    typedef struct packed {
        logic [31:0] pc;
        wb_sel_e     wb_sel;
        logic [4:0]  wb_addr;
        logic        rf_wen;
        logic        br_flg;
        logic        jmp_flg;
        csr_cmd_e    csr_cmd;
        logic [31:0] br_target;
        logic [31:0] alu_out;
        logic [31:0] csr_rdata;
        logic [31:0] trap_vector;
        load_word_u  load_data;
    } retire_pkt_s;

    typedef struct packed {
        logic        en;
        logic [4:0]  addr;
        logic [31:0] data;
    } rf_write_s;

    typedef struct packed {
        logic [31:0] next_pc;
        logic        hazard;
    } redirect_s;

endpackage

`default_nettype wire

// File: hdl/wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module wb_top (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               pkt_valid_i,
    input  wb_pkg::retire_pkt_s     pkt_i,
    output logic                    credit_o,
    output wb_pkg::redirect_s       redirect_o,
    output logic [31:0]             retired_count_o,
    output logic                    halt_o,
    input  wire logic [4:0]         rd_addr_i,
    output logic [31:0]             rd_data_o
);

    import wb_pkg::*;

    logic        head_valid;
    retire_pkt_s head_pkt;
    rf_write_s   rf_wr;

    // credit-managed buffer in front of the stage
    retire_queue i_queue (
        .clk          (clk),
        .reset_i      (reset_i),
        .pkt_valid_i  (pkt_valid_i),
        .pkt_i        (pkt_i),
        .head_valid_o (head_valid),
        .head_pkt_o   (head_pkt),
        .credit_o     (credit_o)
    );

    writeback_stage i_stage (
        .clk             (clk),
        .reset_i         (reset_i),
        .head_valid_i    (head_valid),
        .head_pkt_i      (head_pkt),
        .rf_wr_o         (rf_wr),
        .redirect_o      (redirect_o),
        .retired_count_o (retired_count_o),
        .halt_o          (halt_o)
    );

    // write lands on the pop edge
    reg_file i_rf (
        .clk       (clk),
        .reset_i   (reset_i),
        .wr_i      (rf_wr),
        .rd_addr_i (rd_addr_i),
        .rd_data_o (rd_data_o)
    );

endmodule

`default_nettype wire

// File: hdl/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_defs.svh"

module writeback_stage (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               head_valid_i,
    input  wb_pkg::retire_pkt_s     head_pkt_i,
    output wb_pkg::rf_write_s       rf_wr_o,
    output wb_pkg::redirect_s       redirect_o,
    output logic [31:0]             retired_count_o,
    output logic                    halt_o
);

    import wb_pkg::*;

    load_word_u  ld;
    logic [31:0] pc_plus4;
    logic [31:0] wb_data;
    logic [31:0] next_pc;
    logic        is_trap;
    logic        hazard;

    assign ld       = head_pkt_i.load_data;
    assign pc_plus4 = head_pkt_i.pc + 32'd4;

    // loads use the low byte or halfword of the raw word
    always_comb begin
        case (head_pkt_i.wb_sel)
            WB_MEMB:  wb_data = {{24{ld.bytes[0][7]}}, ld.bytes[0]};
            WB_MEMBU: wb_data = {24'd0, ld.bytes[0]};
            WB_MEMH:  wb_data = {{16{ld.halves[0][15]}}, ld.halves[0]};
            WB_MEMHU: wb_data = {16'd0, ld.halves[0]};
            WB_MEMW:  wb_data = ld.word;
            WB_PC:    wb_data = pc_plus4;
            WB_CSR:   wb_data = head_pkt_i.csr_rdata;
            default:  wb_data = head_pkt_i.alu_out;
        endcase
    end

    assign rf_wr_o.en   = head_valid_i && head_pkt_i.rf_wen;
    assign rf_wr_o.addr = head_pkt_i.wb_addr;
    assign rf_wr_o.data = wb_data;

    assign is_trap = (head_pkt_i.csr_cmd == CSR_ECALL) ||
                     (head_pkt_i.csr_cmd == CSR_MRET)  ||
                     (head_pkt_i.csr_cmd == CSR_SRET);

    // branch beats jump beats trap
    always_comb begin
        if (head_pkt_i.br_flg) begin
            next_pc = head_pkt_i.br_target;
        end else if (head_pkt_i.jmp_flg) begin
            next_pc = head_pkt_i.alu_out;
        end else if (is_trap) begin
            next_pc = head_pkt_i.trap_vector;
        end else begin
            next_pc = pc_plus4;
        end
    end

    assign hazard = head_pkt_i.br_flg || head_pkt_i.jmp_flg || is_trap;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            redirect_o      <= '0;
            retired_count_o <= '0;
            halt_o          <= 1'b0;
        end else if (head_valid_i) begin
            redirect_o.next_pc <= next_pc;
            redirect_o.hazard  <= hazard;
            retired_count_o    <= retired_count_o + 32'd1;
            // sticky until reset
            if (head_pkt_i.pc == `WB_HALT_PC) begin
                halt_o <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: include/wb_defs.svh
`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// architectural integer registers, x0 included
`define WB_NUM_REGS 32

// retire queue entries
`define WB_QUEUE_DEPTH 4

// upstream starts with one credit per queue entry
`define WB_CREDITS `WB_QUEUE_DEPTH

// retiring this pc stops the core
`define WB_HALT_PC 32'hffff_ff00

`endif

// File: run_sim.sh
#!/bin/sh
# builds tb_wb_top with Verilator, runs it into sim.log and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_wb_top \
    || { echo "build failed"; exit 1; }

./obj_dir/Vtb_wb_top > sim.log 2>&1
cat sim.log

grep -q "Simulation FAILED" sim.log \
    && { echo "run reported failure, see sim.log"; exit 1; }
grep -q "Simulation PASSED" sim.log \
    || { echo "run ended without a result, see sim.log"; exit 1; }

echo "run finished without errors"
exit 0

// File: test/tb_wb_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_defs.svh"

module tb_wb_top;

    import wb_pkg::*;

    localparam int MAX_PKTS   = 64;
    localparam int GROUP_SIZE = 8;
    localparam int WAIT_LIMIT = 200;

    logic        clk;
    logic        reset_i;
    logic        pkt_valid_i;
    retire_pkt_s pkt_i;
    logic        credit_o;
    redirect_s   redirect_o;
    logic [31:0] retired_count_o;
    logic        halt_o;
    logic [4:0]  rd_addr_i;
    logic [31:0] rd_data_o;

    // packets and expected results from the data file
    retire_pkt_s pkts [MAX_PKTS];
    logic [31:0] exp_reg [MAX_PKTS];
    logic [31:0] exp_npc [MAX_PKTS];
    logic        exp_haz [MAX_PKTS];
    // register contents as the retired packets leave them
    logic [31:0] reg_image [`WB_NUM_REGS];

    int     num_pkts;
    int     sent;
    int     retired;
    int     credits;
    int     credit_pulses;
    int     mismatches;
    int     errors;
    int     gap;
    integer seed;
    logic   halt_seen;
    logic   aborted;

    wb_top i_dut (
        .clk             (clk),
        .reset_i         (reset_i),
        .pkt_valid_i     (pkt_valid_i),
        .pkt_i           (pkt_i),
        .credit_o        (credit_o),
        .redirect_o      (redirect_o),
        .retired_count_o (retired_count_o),
        .halt_o          (halt_o),
        .rd_addr_i       (rd_addr_i),
        .rd_data_o       (rd_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] pc;
        logic [3:0]  sel;
        logic [4:0]  addr;
        logic        wen;
        logic        br;
        logic        jmp;
        logic [2:0]  csr;
        logic [31:0] bt;
        logic [31:0] alu;
        logic [31:0] crd;
        logic [31:0] tv;
        logic [31:0] ld;
        logic [31:0] er;
        logic [31:0] enp;
        logic        haz;
        fd = $fopen("test/wb_input.txt", "r");
        if (fd == 0) begin
            $display("ERROR: could not open test/wb_input.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // blank lines and column notes
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        pc, sel, addr, wen, br, jmp, csr, bt, alu, crd, tv, ld,
                        er, enp, haz);
            if (n != 15) begin
                $display("ERROR: malformed line in data file: %s", line);
                errors++;
            end else if (num_pkts >= MAX_PKTS) begin
                $display("ERROR: data file holds more than %0d packets", MAX_PKTS);
                errors++;
            end else begin
                pkts[num_pkts].pc             = pc;
                pkts[num_pkts].wb_sel         = wb_sel_e'(sel);
                pkts[num_pkts].wb_addr        = addr;
                pkts[num_pkts].rf_wen         = wen;
                pkts[num_pkts].br_flg         = br;
                pkts[num_pkts].jmp_flg        = jmp;
                pkts[num_pkts].csr_cmd        = csr_cmd_e'(csr);
                pkts[num_pkts].br_target      = bt;
                pkts[num_pkts].alu_out        = alu;
                pkts[num_pkts].csr_rdata      = crd;
                pkts[num_pkts].trap_vector    = tv;
                pkts[num_pkts].load_data.word = ld;
                exp_reg[num_pkts]             = er;
                exp_npc[num_pkts]             = enp;
                exp_haz[num_pkts]             = haz;
                num_pkts++;
            end
        end
        $fclose(fd);
    endtask

    // credit pulse means the oldest outstanding packet just retired
    task automatic check_retire();
        int idx;
        idx = retired;
        if (idx >= sent) begin
            $display("ERROR at %0t: credit pulse with no packet outstanding", $time);
            errors++;
            return;
        end
        retired++;
        if (pkts[idx].pc == `WB_HALT_PC) begin
            halt_seen = 1'b1;
        end
        reg_image[pkts[idx].wb_addr] = exp_reg[idx];
        if (redirect_o.next_pc !== exp_npc[idx]) begin
            $display("MISMATCH at %0t: redirect_o.next_pc expected %08h got %08h",
                     $time, exp_npc[idx], redirect_o.next_pc);
            mismatches++;
        end
        if (redirect_o.hazard !== exp_haz[idx]) begin
            $display("MISMATCH at %0t: redirect_o.hazard expected %0b got %0b",
                     $time, exp_haz[idx], redirect_o.hazard);
            mismatches++;
        end
        if (retired_count_o !== 32'(retired)) begin
            $display("MISMATCH at %0t: retired_count_o expected %0d got %0d",
                     $time, retired, retired_count_o);
            mismatches++;
        end
        if (halt_o !== halt_seen) begin
            $display("MISMATCH at %0t: halt_o expected %0b got %0b",
                     $time, halt_seen, halt_o);
            mismatches++;
        end
    endtask

    // advance to the next falling edge and collect any returned credit
    task automatic tick();
        @(negedge clk);
        if (credit_o) begin
            credit_pulses++;
            credits++;
            check_retire();
        end
    endtask

    task automatic wait_credit();
        int waited;
        waited = 0;
        while (credits == 0 && waited < WAIT_LIMIT) begin
            tick();
            waited++;
        end
        if (credits == 0) begin
            $display("ERROR at %0t: no credit came back within %0d cycles",
                     $time, WAIT_LIMIT);
            errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic send_packet(int idx);
        pkt_valid_i = 1'b1;
        pkt_i       = pkts[idx];
        credits--;
        sent++;
        tick();
        pkt_valid_i = 1'b0;
    endtask

    task automatic drain_queue();
        int waited;
        waited = 0;
        while (retired < sent && waited < WAIT_LIMIT) begin
            tick();
            waited++;
        end
        if (retired < sent) begin
            $display("ERROR at %0t: queue did not drain, %0d of %0d packets retired",
                     $time, retired, sent);
            errors++;
            aborted = 1'b1;
        end
    endtask

    // read every register back, only while nothing is in flight
    task automatic check_regs();
        for (int a = 0; a < `WB_NUM_REGS; a++) begin
            @(negedge clk);
            rd_addr_i = 5'(a);
            @(posedge clk);
            if (rd_data_o !== reg_image[a]) begin
                $display("MISMATCH at %0t: rd_data_o (x%0d) expected %08h got %08h",
                         $time, a, reg_image[a], rd_data_o);
                mismatches++;
            end
        end
        tick();
    endtask

    initial begin
        reset_i       = 1'b1;
        pkt_valid_i   = 1'b0;
        pkt_i         = '0;
        rd_addr_i     = 5'd0;
        num_pkts      = 0;
        sent          = 0;
        retired       = 0;
        credits       = `WB_CREDITS;
        credit_pulses = 0;
        mismatches    = 0;
        errors        = 0;
        seed          = 32'h20ad;
        halt_seen     = 1'b0;
        aborted       = 1'b0;
        for (int r = 0; r < `WB_NUM_REGS; r++) begin
            reg_image[r] = 32'd0;
        end

        load_vectors();

        repeat (4) @(negedge clk);
        reset_i = 1'b0;

        // outputs straight out of reset
        if (credit_o !== 1'b0) begin
            $display("MISMATCH at %0t: credit_o expected 0 got %0b", $time, credit_o);
            mismatches++;
        end
        if (redirect_o.hazard !== 1'b0) begin
            $display("MISMATCH at %0t: redirect_o.hazard expected 0 got %0b",
                     $time, redirect_o.hazard);
            mismatches++;
        end
        if (redirect_o.next_pc !== 32'd0) begin
            $display("MISMATCH at %0t: redirect_o.next_pc expected 00000000 got %08h",
                     $time, redirect_o.next_pc);
            mismatches++;
        end
        if (halt_o !== 1'b0) begin
            $display("MISMATCH at %0t: halt_o expected 0 got %0b", $time, halt_o);
            mismatches++;
        end
        if (retired_count_o !== 32'd0) begin
            $display("MISMATCH at %0t: retired_count_o expected 0 got %0d",
                     $time, retired_count_o);
            mismatches++;
        end
        check_regs();

        for (int i = 0; i < num_pkts && !aborted; i++) begin
            // even groups get random gaps, odd groups go back to back
            if (((i / GROUP_SIZE) % 2) == 0) begin
                gap = int'($unsigned($random(seed)) % 32'd4);
            end else begin
                gap = 0;
            end
            repeat (gap) tick();
            wait_credit();
            if (aborted) begin
                break;
            end
            send_packet(i);
            if (((i + 1) % GROUP_SIZE) == 0 || i == num_pkts - 1) begin
                drain_queue();
                if (!aborted) begin
                    check_regs();
                end
            end
        end

        if (!aborted) begin
            if (retired_count_o !== 32'(sent)) begin
                $display("MISMATCH at %0t: retired_count_o expected %0d got %0d",
                         $time, sent, retired_count_o);
                mismatches++;
            end
            if (credit_pulses != sent) begin
                $display("ERROR: %0d credit pulses seen for %0d packets sent",
                         credit_pulses, sent);
                errors++;
            end
            if (halt_o !== halt_seen) begin
                $display("MISMATCH at %0t: halt_o expected %0b got %0b",
                         $time, halt_seen, halt_o);
                mismatches++;
            end
        end

        $display("checks done: %0d mismatches, %0d other errors", mismatches, errors);
        if (mismatches == 0 && errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/wb_input.txt
# pc sel rd wen br jmp csr br_target alu_out csr_rdata trap_vec load_data
# then expected rd value, expected next_pc, expected hazard (all hex)
00001000 1 01 1 0 0 0 00002000 0badf00d 00000000 00000800 12345680 ffffff80 00001004 0
00001004 1 02 1 0 0 0 00002000 0badf00d 00000000 00000800 aabbcc7f 0000007f 00001008 0
00001008 2 03 1 0 0 0 00002000 0badf00d 00000000 00000800 000000f0 000000f0 0000100c 0
0000100c 3 04 1 0 0 0 00002000 0badf00d 00000000 00000800 12348001 ffff8001 00001010 0
00001010 3 05 1 0 0 0 00002000 0badf00d 00000000 00000800 ffff7ffe 00007ffe 00001014 0
00001014 4 06 1 0 0 0 00002000 0badf00d 00000000 00000800 0000c350 0000c350 00001018 0
00001018 5 07 1 0 0 0 00002000 0badf00d 00000000 00000800 deadbeef deadbeef 0000101c 0
0000101c 2 08 1 0 0 0 00002000 0badf00d 00000000 00000800 5555557a 0000007a 00001020 0
00001020 0 09 1 0 0 0 00002000 13579bdf 00000000 00000800 00000000 13579bdf 00001024 0
00001024 6 0a 1 0 0 0 00002000 0badf00d 00000000 00000800 00000000 00001028 00001028 0
00001028 7 0b 1 0 0 1 00002000 0badf00d 00001800 00000800 00000000 00001800 0000102c 0
0000102c 0 09 0 0 0 0 00002000 00000bad 00000000 00000800 00000000 13579bdf 00001030 0
00001030 0 00 1 0 0 0 00002000 cafef00d 00000000 00000800 00000000 00000000 00001034 0
00001034 9 0c 1 0 0 0 00002000 0000abcd 00000000 00000800 00000000 0000abcd 00001038 0
00001038 5 01 0 0 0 0 00002000 00000000 00000000 00000800 11111111 ffffff80 0000103c 0
0000103c 6 0d 1 0 0 0 00002000 00000000 00000000 00000800 00000000 00001040 00001040 0
00001040 0 0e 1 1 1 0 00002000 00003000 00000000 00000800 00000000 00003000 00002000 1
00002000 6 0f 1 0 1 4 00002000 00004000 00000000 00000800 00000000 00002004 00004000 1
00004000 0 10 1 0 0 4 00002000 00000011 00000000 00000800 00000000 00000011 00000800 1
00000800 0 11 1 0 0 5 00002000 00000022 00000000 00000900 00000000 00000022 00000900 1
00000900 7 12 1 0 0 6 00002000 00000000 00000304 00000a00 00000000 00000304 00000a00 1
00000a00 0 13 1 0 0 0 00002000 00000033 00000000 00000800 00000000 00000033 00000a04 0
00000a04 0 14 1 1 0 5 00000c00 00000044 00000000 00000900 00000000 00000044 00000c00 1
00000c00 0 15 1 0 0 3 00002000 00000055 00000000 00000800 00000000 00000055 00000c04 0
00000c04 1 16 1 0 0 0 00002000 0badf00d 00000000 00000800 000080ff ffffffff 00000c08 0
00000c08 3 17 1 0 0 0 00002000 0badf00d 00000000 00000800 00017fff 00007fff 00000c0c 0
00000c0c 4 18 1 0 0 0 00002000 0badf00d 00000000 00000800 1234ffff 0000ffff 00000c10 0
00000c10 0 19 1 0 1 0 00002000 fffffefc 00000000 00000800 00000000 fffffefc fffffefc 1
fffffefc 6 1a 1 0 0 0 00002000 00000000 00000000 00000800 00000000 ffffff00 ffffff00 0
ffffff00 0 1b 1 0 0 0 00002000 00000777 00000000 00000800 00000000 00000777 ffffff04 0
ffffff04 0 1f 1 0 0 0 00002000 0000001f 00000000 00000800 00000000 0000001f ffffff08 0
ffffff08 5 1c 1 0 0 0 00002000 0badf00d 00000000 00000800 80000000 80000000 ffffff0c 0
